//--- files.f
hw/vmul_pkg.sv
hw/vmul_sequencer.sv
hw/vmul_operand_fetch.sv
hw/vmul_product.sv
hw/vmul_writeback.sv
hw/vmul_unit.sv
testbench/vreg_file_model.sv
testbench/vmul_tb.sv

//--- hw/vmul_operand_fetch.sv
/*
 * Operand fetch. Selects the current half of both sources and
 * spreads its bytes into 17-bit signed multiplier fields.
 */

`timescale 1ns/1ps

module vmul_operand_fetch (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  vmul_pkg::mul_ctrl_t  ctrl_i,
    input  vmul_pkg::vreg_t      vs1_i,
    input  vmul_pkg::vreg_t      vs2_i,
    output vmul_pkg::mul_ctrl_t  ctrl_o,
    output vmul_pkg::op_fields_t op1_o,
    output vmul_pkg::op_fields_t op2_o
);

    import vmul_pkg::*;

    // upper halves wait here for the second part
    op_word_t vs1_shift_q, vs2_shift_q;
    op_word_t op1_word, op2_word;
    logic     sew_8, sew_32;

    // swap picks the op2 halfword order for the 32-bit cross products
    function automatic op_fields_t spread_fields(op_word_t w, logic sgn, logic swap,
                                                 logic is_8, logic is_32);
        op_fields_t    f;
        op_mask_t      s;
        logic [15:0]   hw_lo, hw_hi;
        int unsigned   b;
        f = '0;
        for (b = 0; b < OP_BYTES; b++) begin
            s[b] = sgn & w[8*b+7];
        end
        for (int i = 0; i < LANES_32; i++) begin
            b     = 4 * i;
            hw_lo = w[32*i +: 16];
            hw_hi = w[32*i+16 +: 16];
            f[FIELD_W*(b+3) +: FIELD_W] = is_32 ? {swap ? 1'b0 : s[b+3], swap ? hw_lo : hw_hi}
                                                : {{9{s[b+3]}}, w[32*i+24 +: 8]};
            f[FIELD_W*(b+2) +: FIELD_W] = is_8 ? {{9{s[b+2]}}, w[32*i+16 +: 8]}
                                               : {s[b+3], hw_hi};
            f[FIELD_W*(b+1) +: FIELD_W] = is_32 ? {swap ? s[b+3] : 1'b0, swap ? hw_hi : hw_lo}
                                                : {{9{s[b+1]}}, w[32*i+8 +: 8]};
            // lower halfword stays unsigned when it is part of a 32-bit element
            f[FIELD_W*b +: FIELD_W] = is_8 ? {{9{s[b]}}, w[32*i +: 8]}
                                           : {~is_32 & s[b+1], hw_lo};
        end
        return f;
    endfunction

    always_ff @(posedge clk_i) begin
        if (ctrl_i.valid && ctrl_i.first_part) begin
            vs1_shift_q <= vs1_i[VREG_W-1:MUL_OP_W];
            vs2_shift_q <= vs2_i[VREG_W-1:MUL_OP_W];
        end
    end

    assign op1_word = ctrl_i.first_part ? vs1_i[MUL_OP_W-1:0] : vs1_shift_q;
    assign op2_word = ctrl_i.first_part ? vs2_i[MUL_OP_W-1:0] : vs2_shift_q;
    assign sew_8    = ctrl_i.sew == VSEW_8;
    assign sew_32   = ctrl_i.sew == VSEW_32;

    always_ff @(posedge clk_i) begin
        op1_o <= spread_fields(op1_word, ctrl_i.mode.op1_signed, 1'b0, sew_8, sew_32);
        op2_o <= spread_fields(op2_word, ctrl_i.mode.op2_signed, 1'b1, sew_8, sew_32);
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ctrl_o <= '0;
        end else begin
            ctrl_o <= ctrl_i;
        end
    end

endmodule

//--- hw/vmul_pkg.sv
/*
 * Vector multiply unit shared definitions.
 * Widths, value types, encodings and the pipeline control word.
 */

package vmul_pkg;

    //////////////////////////////////////////////////
    // widths

    localparam int unsigned MUL_OP_W       = 64;
    localparam int unsigned PARTS_PER_VREG = 2;
    localparam int unsigned VREG_W         = MUL_OP_W * PARTS_PER_VREG;
    localparam int unsigned OP_BYTES       = MUL_OP_W / 8;
    localparam int unsigned VMSK_W         = VREG_W / 8;
    // three group bits above the part bit
    localparam int unsigned COUNT_W        = 3 + $clog2(PARTS_PER_VREG);
    localparam int unsigned VL_W           = $clog2(VMSK_W) + 3;

    // signed operand field per byte and its product
    localparam int unsigned FIELD_W  = 17;
    localparam int unsigned PROD_W   = 2 * FIELD_W - 1;
    localparam int unsigned LANES_32 = MUL_OP_W / 32;

    //////////////////////////////////////////////////
    // value types

    typedef logic [VREG_W-1:0]           vreg_t;
    typedef logic [VMSK_W-1:0]           vmsk_t;
    typedef logic [MUL_OP_W-1:0]         op_word_t;
    typedef logic [OP_BYTES-1:0]         op_mask_t;
    typedef logic [4:0]                  vaddr_t;
    typedef logic [VL_W-1:0]             vl_t;
    typedef logic [COUNT_W-1:0]          part_count_t;
    typedef logic [OP_BYTES*FIELD_W-1:0] op_fields_t;
    typedef logic signed [PROD_W-1:0]    prod_t;

    //////////////////////////////////////////////////
    // encodings

    typedef enum logic [1:0] {VSEW_8, VSEW_16, VSEW_32} sew_e;
    typedef enum logic [1:0] {LMUL_1, LMUL_2, LMUL_4, LMUL_8} lmul_e;
    typedef enum logic {MUL_VMUL, MUL_VMULH} mul_op_e;
    typedef enum logic {SEQ_IDLE, SEQ_BUSY} seq_state_e;

    typedef struct packed {
        mul_op_e op;
        logic    op1_signed;
        logic    op2_signed;
    } mul_mode_t;

    // travels with every part down the pipeline
    typedef struct packed {
        logic        valid;
        part_count_t count;
        logic        first_part;
        logic        vd_store;
        sew_e        sew;
        mul_mode_t   mode;
        vaddr_t      vd;
        vl_t         vl;
        logic        vl_0;
    } mul_ctrl_t;

endpackage

//--- hw/vmul_product.sv
/*
 * Product stage. Byte-wise 17x17 signed multipliers, 32-bit
 * recombination and low or high half selection per element.
 */

`timescale 1ns/1ps

module vmul_product (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  vmul_pkg::mul_ctrl_t  ctrl_i,
    input  vmul_pkg::op_fields_t op1_i,
    input  vmul_pkg::op_fields_t op2_i,
    output vmul_pkg::mul_ctrl_t  ctrl_o,
    output vmul_pkg::op_word_t   result_o
);

    import vmul_pkg::*;

    prod_t       prod_d [OP_BYTES];
    prod_t       prod_q [OP_BYTES];
    mul_ctrl_t   ctrl_mid_q;
    logic [63:0] lane_sum [LANES_32];
    logic        sel_high;
    op_word_t    result_d;

    //////////////////////////////////////////////////
    // partial products

    for (genvar g = 0; g < OP_BYTES; g++) begin : g_byte_mul
        assign prod_d[g] = $signed(op1_i[FIELD_W*g +: FIELD_W])
                         * $signed(op2_i[FIELD_W*g +: FIELD_W]);
    end

    always_ff @(posedge clk_i) begin
        prod_q <= prod_d;
    end

    //////////////////////////////////////////////////
    // combination and selection

    // lo*lo + (lo*hi + hi*lo) << 16 + hi*hi << 32
    always_comb begin
        for (int i = 0; i < LANES_32; i++) begin
            lane_sum[i] = {32'b0, prod_q[4*i][31:0]}
                        + {{16{prod_q[4*i+1][32]}}, prod_q[4*i+1][31:0], 16'b0}
                        + {{16{prod_q[4*i+3][32]}}, prod_q[4*i+3][31:0], 16'b0}
                        + {prod_q[4*i+2][31:0], 32'b0};
        end
    end

    assign sel_high = ctrl_mid_q.mode.op == MUL_VMULH;

    always_comb begin
        result_d = '0;
        case (ctrl_mid_q.sew)
            VSEW_8: begin
                for (int j = 0; j < OP_BYTES; j++) begin
                    result_d[8*j +: 8] = sel_high ? prod_q[j][15:8] : prod_q[j][7:0];
                end
            end
            VSEW_16: begin
                // halfword products sit in the even blocks
                for (int j = 0; j < OP_BYTES / 2; j++) begin
                    result_d[16*j +: 16] = sel_high ? prod_q[2*j][31:16] : prod_q[2*j][15:0];
                end
            end
            VSEW_32: begin
                for (int j = 0; j < LANES_32; j++) begin
                    result_d[32*j +: 32] = sel_high ? lane_sum[j][63:32] : lane_sum[j][31:0];
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        result_o <= result_d;
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ctrl_mid_q <= '0;
            ctrl_o     <= '0;
        end else begin
            ctrl_mid_q <= ctrl_i;
            ctrl_o     <= ctrl_mid_q;
        end
    end

endmodule

//--- hw/vmul_sequencer.sv
/*
 * Multiply sequencer. Accepts an instruction and issues one
 * 64-bit part per cycle across the register group.
 */

`timescale 1ns/1ps

module vmul_sequencer (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  logic                op_rdy_i,
    input  vmul_pkg::mul_mode_t mode_i,
    input  vmul_pkg::sew_e      sew_i,
    input  vmul_pkg::lmul_e     lmul_i,
    input  vmul_pkg::vl_t       vl_i,
    input  logic                vl_0_i,
    input  vmul_pkg::vaddr_t    vs1_i,
    input  vmul_pkg::vaddr_t    vs2_i,
    input  vmul_pkg::vaddr_t    vd_i,
    output logic                op_ack_o,
    output vmul_pkg::vaddr_t    rd1_addr_o,
    output vmul_pkg::vaddr_t    rd2_addr_o,
    output vmul_pkg::mul_ctrl_t ctrl_o
);

    import vmul_pkg::*;

    seq_state_e  state_q;
    part_count_t count_q;

    // latched instruction
    mul_mode_t mode_q;
    sew_e      sew_q;
    lmul_e     lmul_q;
    vl_t       vl_q;
    logic      vl_0_q;
    vaddr_t    vs1_q, vs2_q, vd_q;

    logic       busy;
    logic [2:0] grp_mask;
    logic       last_part;

    assign busy = state_q == SEQ_BUSY;

    // group bits that have to be all ones on the last register
    always_comb begin
        case (lmul_q)
            LMUL_2:  grp_mask = 3'b001;
            LMUL_4:  grp_mask = 3'b011;
            LMUL_8:  grp_mask = 3'b111;
            default: grp_mask = 3'b000;
        endcase
    end

    assign last_part = busy & count_q[0]
                     & ((count_q[COUNT_W-1:1] & grp_mask) == grp_mask);

    // nothing is acknowledged while reset is held
    assign op_ack_o = async_rst_ni & op_rdy_i & (~busy | last_part);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= SEQ_IDLE;
            count_q <= '0;
        end else if (op_ack_o) begin
            state_q <= SEQ_BUSY;
            count_q <= '0;
        end else if (busy) begin
            count_q <= count_q + part_count_t'(1);
            if (last_part) begin
                state_q <= SEQ_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            mode_q <= mode_i;
            sew_q  <= sew_i;
            lmul_q <= lmul_i;
            vl_q   <= vl_i;
            vl_0_q <= vl_0_i;
            vs1_q  <= vs1_i;
            vs2_q  <= vs2_i;
            vd_q   <= vd_i;
        end else if (busy && count_q[0]) begin
            // step to the next register of the group
            vs1_q[2:0] <= vs1_q[2:0] + 3'd1;
            vs2_q[2:0] <= vs2_q[2:0] + 3'd1;
            vd_q[2:0]  <= vd_q[2:0] + 3'd1;
        end
    end

    assign rd1_addr_o = vs1_q;
    assign rd2_addr_o = vs2_q;

    always_comb begin
        ctrl_o.valid      = busy;
        ctrl_o.count      = count_q;
        ctrl_o.first_part = ~count_q[0];
        ctrl_o.vd_store   = count_q[0];
        ctrl_o.sew        = sew_q;
        ctrl_o.mode       = mode_q;
        ctrl_o.vd         = vd_q;
        ctrl_o.vl         = vl_q;
        ctrl_o.vl_0       = vl_0_q;
    end

endmodule

//--- hw/vmul_unit.sv
/*
 * Vector multiply unit top level.
 * Chains sequencer, operand fetch, product and writeback stages.
 */

`timescale 1ns/1ps

module vmul_unit (
    input  logic                clk_i,
    input  logic                async_rst_ni,

    input  logic                op_rdy_i,
    output logic                op_ack_o,
    input  vmul_pkg::mul_mode_t mode_i,
    input  vmul_pkg::sew_e      sew_i,
    input  vmul_pkg::lmul_e     lmul_i,
    input  vmul_pkg::vl_t       vl_i,
    input  logic                vl_0_i,
    input  vmul_pkg::vaddr_t    vs1_i,
    input  vmul_pkg::vaddr_t    vs2_i,
    input  vmul_pkg::vaddr_t    vd_i,

    // register file ports
    output vmul_pkg::vaddr_t    vreg_rd1_addr_o,
    output vmul_pkg::vaddr_t    vreg_rd2_addr_o,
    input  vmul_pkg::vreg_t     vreg_rd1_i,
    input  vmul_pkg::vreg_t     vreg_rd2_i,
    output logic                vreg_wr_en_o,
    output vmul_pkg::vaddr_t    vreg_wr_addr_o,
    output vmul_pkg::vmsk_t     vreg_wr_mask_o,
    output vmul_pkg::vreg_t     vreg_wr_o
);

    import vmul_pkg::*;

    mul_ctrl_t  seq_ctrl, fetch_ctrl, prod_ctrl;
    op_fields_t op1_fields, op2_fields;
    op_word_t   prod_result;

    vmul_sequencer u_sequencer (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_rdy_i     (op_rdy_i),
        .mode_i       (mode_i),
        .sew_i        (sew_i),
        .lmul_i       (lmul_i),
        .vl_i         (vl_i),
        .vl_0_i       (vl_0_i),
        .vs1_i        (vs1_i),
        .vs2_i        (vs2_i),
        .vd_i         (vd_i),
        .op_ack_o     (op_ack_o),
        .rd1_addr_o   (vreg_rd1_addr_o),
        .rd2_addr_o   (vreg_rd2_addr_o),
        .ctrl_o       (seq_ctrl)
    );

    vmul_operand_fetch u_operand_fetch (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .ctrl_i       (seq_ctrl),
        .vs1_i        (vreg_rd1_i),
        .vs2_i        (vreg_rd2_i),
        .ctrl_o       (fetch_ctrl),
        .op1_o        (op1_fields),
        .op2_o        (op2_fields)
    );

    vmul_product u_product (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .ctrl_i       (fetch_ctrl),
        .op1_i        (op1_fields),
        .op2_i        (op2_fields),
        .ctrl_o       (prod_ctrl),
        .result_o     (prod_result)
    );

    vmul_writeback u_writeback (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .ctrl_i       (prod_ctrl),
        .result_i     (prod_result),
        .wr_en_o      (vreg_wr_en_o),
        .wr_addr_o    (vreg_wr_addr_o),
        .wr_mask_o    (vreg_wr_mask_o),
        .wr_data_o    (vreg_wr_o)
    );

endmodule

//--- hw/vmul_writeback.sv
/*
 * Writeback. Collects the parts of a register with their tail
 * byte mask and writes the register once complete.
 */

`timescale 1ns/1ps

module vmul_writeback (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  vmul_pkg::mul_ctrl_t ctrl_i,
    input  vmul_pkg::op_word_t  result_i,
    output logic                wr_en_o,
    output vmul_pkg::vaddr_t    wr_addr_o,
    output vmul_pkg::vmsk_t     wr_mask_o,
    output vmul_pkg::vreg_t     wr_data_o
);

    import vmul_pkg::*;

    mul_ctrl_t ctrl_q;
    op_mask_t  part_mask;
    vreg_t     data_shift_q;
    vmsk_t     mask_shift_q;

    // byte index within the group against the last valid byte
    always_comb begin
        for (int b = 0; b < OP_BYTES; b++) begin
            part_mask[b] = ~ctrl_i.vl_0
                         & (vl_t'(ctrl_i.count * OP_BYTES + b) <= ctrl_i.vl);
        end
    end

    // parts enter from the top, first part ends up in the low half
    always_ff @(posedge clk_i) begin
        if (ctrl_i.valid) begin
            data_shift_q <= {result_i, data_shift_q[VREG_W-1:MUL_OP_W]};
            mask_shift_q <= {part_mask, mask_shift_q[VMSK_W-1:OP_BYTES]};
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ctrl_q  <= '0;
            wr_en_o <= 1'b0;
        end else begin
            ctrl_q  <= ctrl_i;
            wr_en_o <= ctrl_q.valid & ctrl_q.vd_store;
        end
    end

    always_ff @(posedge clk_i) begin
        wr_addr_o <= ctrl_q.vd;
        wr_mask_o <= mask_shift_q;
        wr_data_o <= data_shift_q;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the vector multiply testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module vmul_tb -f files.f -o vmul_sim

./obj_dir/vmul_sim 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- testbench/vmul_tb.sv
/*
 * Testbench for the vector multiply unit. Loads random registers,
 * issues instructions and checks every register write.
 */

`timescale 1ns/1ps

module vmul_tb;

    import vmul_pkg::*;

    localparam int unsigned ACK_TIMEOUT   = 100;
    localparam int unsigned DRAIN_TIMEOUT = 400;

    logic      clk, rst_n;
    logic      op_rdy, op_ack;
    mul_mode_t mode;
    sew_e      sew;
    lmul_e     lmul;
    vl_t       vl;
    logic      vl_0;
    vaddr_t    vs1, vs2, vd;
    vaddr_t    rd1_addr, rd2_addr, wr_addr;
    vreg_t     rd1_data, rd2_data, wr_data;
    logic      wr_en;
    vmsk_t     wr_mask;
    logic      load_en;
    vaddr_t    load_addr;
    vreg_t     load_data;

    // loaded register contents and the writes still to come
    vreg_t       regs [32];
    vaddr_t      exp_addr_q [$];
    vreg_t       exp_data_q [$];
    vmsk_t       exp_mask_q [$];
    int unsigned cycle;
    int unsigned accept_cycle;

    vmul_unit uut (
        .clk_i           (clk),
        .async_rst_ni    (rst_n),
        .op_rdy_i        (op_rdy),
        .op_ack_o        (op_ack),
        .mode_i          (mode),
        .sew_i           (sew),
        .lmul_i          (lmul),
        .vl_i            (vl),
        .vl_0_i          (vl_0),
        .vs1_i           (vs1),
        .vs2_i           (vs2),
        .vd_i            (vd),
        .vreg_rd1_addr_o (rd1_addr),
        .vreg_rd2_addr_o (rd2_addr),
        .vreg_rd1_i      (rd1_data),
        .vreg_rd2_i      (rd2_data),
        .vreg_wr_en_o    (wr_en),
        .vreg_wr_addr_o  (wr_addr),
        .vreg_wr_mask_o  (wr_mask),
        .vreg_wr_o       (wr_data)
    );

    vreg_file_model u_vreg (
        .clk_i       (clk),
        .load_en_i   (load_en),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .rd1_addr_i  (rd1_addr),
        .rd2_addr_i  (rd2_addr),
        .rd1_o       (rd1_data),
        .rd2_o       (rd2_data),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_mask_i   (wr_mask),
        .wr_data_i   (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    //////////////////////////////////////////////////
    // reference model

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input vreg_t got, input vreg_t exp);
        abort_run($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, exp));
    endtask

    // element products at double width with the low or high SEW bits kept
    function automatic vreg_t expect_data(input vreg_t a, input vreg_t b, input sew_e s,
                                          input mul_mode_t m);
        vreg_t       r;
        logic [63:0] x, y, p, lim;
        int unsigned w;
        w   = (s == VSEW_8) ? 8 : (s == VSEW_16) ? 16 : 32;
        lim = (64'd1 << w) - 64'd1;
        r   = '0;
        for (int unsigned e = 0; e < VREG_W / w; e++) begin
            x = 64'(a >> (e * w)) & lim;
            y = 64'(b >> (e * w)) & lim;
            x = (m.op1_signed && x[w-1]) ? (x | ~lim) : x;
            y = (m.op2_signed && y[w-1]) ? (y | ~lim) : y;
            p = x * y;
            p = (m.op == MUL_VMULH) ? (p >> w) : p;
            r = r | (vreg_t'(p & lim) << (e * w));
        end
        return r;
    endfunction

    // byte k*16+i of the group is written up to vl
    function automatic vmsk_t expect_mask(input int unsigned k, input vl_t v, input logic v0);
        vmsk_t m;
        for (int unsigned i = 0; i < VMSK_W; i++) begin
            m[i] = !v0 && (k * VMSK_W + i <= 32'(v));
        end
        return m;
    endfunction

    //////////////////////////////////////////////////
    // stimulus

    task automatic send(input mul_mode_t m, input sew_e s, input lmul_e l, input vl_t v,
                        input logic v0, input vaddr_t a1, input vaddr_t a2, input vaddr_t ad);
        vaddr_t      r1, r2, rd;
        int unsigned waited;
        for (int k = 0; k < (1 << int'(l)); k++) begin
            r1 = {a1[4:3], a1[2:0] + 3'(k)};
            r2 = {a2[4:3], a2[2:0] + 3'(k)};
            rd = {ad[4:3], ad[2:0] + 3'(k)};
            exp_addr_q.push_back(rd);
            exp_data_q.push_back(expect_data(regs[r1], regs[r2], s, m));
            exp_mask_q.push_back(expect_mask(k, v, v0));
        end
        op_rdy <= 1'b1;
        mode   <= m;
        sew    <= s;
        lmul   <= l;
        vl     <= v;
        vl_0   <= v0;
        vs1    <= a1;
        vs2    <= a2;
        vd     <= ad;
        waited = 0;
        @(negedge clk);
        while (!op_ack) begin
            waited++;
            if (waited > ACK_TIMEOUT) begin
                abort_run("timeout waiting for op_ack_o");
            end
            @(negedge clk);
        end
        accept_cycle = cycle;
        @(posedge clk);
    endtask

    task automatic drain();
        int unsigned waited;
        waited = 0;
        while (exp_addr_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("timeout waiting for register writes");
            end
        end
    endtask

    // every write is compared against the oldest expected one
    always @(negedge clk) begin
        vaddr_t a;
        vreg_t  d;
        vmsk_t  m;
        if (wr_en) begin
            if (exp_addr_q.size() == 0) begin
                abort_run($sformatf("write to register %0d with no instruction", wr_addr));
            end
            a = exp_addr_q.pop_front();
            d = exp_data_q.pop_front();
            m = exp_mask_q.pop_front();
            assert (wr_addr == a)
                else report_mismatch("vreg_wr_addr_o", vreg_t'(wr_addr), vreg_t'(a));
            for (int b = 0; b < VMSK_W; b++) begin
                if (m[b]) begin
                    assert (wr_data[8*b +: 8] == d[8*b +: 8])
                        else report_mismatch($sformatf("vreg_wr_o byte %0d", b),
                                             vreg_t'(wr_data[8*b +: 8]), vreg_t'(d[8*b +: 8]));
                end
            end
            assert (wr_mask == m)
                else report_mismatch("vreg_wr_mask_o", vreg_t'(wr_mask), vreg_t'(m));
        end
    end

    initial begin
        mul_mode_t   m;
        vreg_t       v;
        int unsigned n;
        // a request held during reset must not be acknowledged
        op_rdy    <= 1'b1;
        mode      <= '0;
        sew       <= VSEW_8;
        lmul      <= LMUL_1;
        vl        <= '0;
        vl_0      <= 1'b0;
        vs1       <= '0;
        vs2       <= '0;
        vd        <= '0;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        rst_n     <= 1'b0;
        void'($urandom(32'h2131_51cc));

        repeat (10) begin
            @(negedge clk);
            assert (!op_ack) else report_mismatch("op_ack_o", vreg_t'(op_ack), '0);
        end
        @(posedge clk);
        op_rdy <= 1'b0;
        rst_n  <= 1'b1;

        // sources live in v0..v15, destinations in v16..v31
        for (int r = 0; r < 32; r++) begin
            v = {$urandom(), $urandom(), $urandom(), $urandom()};
            regs[r] = v;
            load_en   <= 1'b1;
            load_addr <= vaddr_t'(r);
            load_data <= v;
            @(posedge clk);
        end
        load_en <= 1'b0;

        // low and high products over every SEW and sign pairing
        n = 0;
        for (int op = 0; op < 2; op++) begin
            for (int s = 0; s < 3; s++) begin
                for (int sg = 0; sg < 4; sg++) begin
                    m = '{op: mul_op_e'(op), op1_signed: sg[0], op2_signed: sg[1]};
                    send(m, sew_e'(s), LMUL_1, vl_t'(15), 1'b0, vaddr_t'(n % 8),
                         vaddr_t'(8 + n % 8), vaddr_t'(16 + n % 16));
                    n++;
                end
            end
        end
        op_rdy <= 1'b0;
        drain();

        // register groups at full length
        for (int l = 1; l < 4; l++) begin
            m = mul_mode_t'(3'($urandom()));
            send(m, sew_e'($urandom() % 3), lmul_e'(l), vl_t'(127), 1'b0,
                 vaddr_t'(8 - (1 << l)), vaddr_t'(8), vaddr_t'(16 + 4 * (l - 1)));
        end
        op_rdy <= 1'b0;
        drain();

        // vector length tails and zero length
        m = mul_mode_t'(3'($urandom()));
        send(m, VSEW_16, LMUL_1, vl_t'(5), 1'b0, vaddr_t'(1), vaddr_t'(9), vaddr_t'(17));
        send(m, VSEW_8, LMUL_2, vl_t'($urandom() % 32), 1'b0, vaddr_t'(2), vaddr_t'(10),
             vaddr_t'(18));
        send(m, VSEW_32, LMUL_8, vl_t'(37), 1'b0, vaddr_t'(0), vaddr_t'(8), vaddr_t'(24));
        send(m, VSEW_8, LMUL_4, vl_t'(127), 1'b1, vaddr_t'(4), vaddr_t'(12), vaddr_t'(20));
        op_rdy <= 1'b0;
        drain();

        // request still held after acceptance gets no second ack
        send(m, VSEW_8, LMUL_1, vl_t'(15), 1'b0, vaddr_t'(3), vaddr_t'(11), vaddr_t'(19));
        @(negedge clk);
        assert (!op_ack) else report_mismatch("op_ack_o", vreg_t'(op_ack), '0);
        @(posedge clk);
        op_rdy <= 1'b0;
        drain();

        // second instruction is taken in the last part of the first
        send(m, VSEW_16, LMUL_2, vl_t'(127), 1'b0, vaddr_t'(4), vaddr_t'(12), vaddr_t'(20));
        n = accept_cycle;
        send(m, VSEW_32, LMUL_1, vl_t'(127), 1'b0, vaddr_t'(5), vaddr_t'(13), vaddr_t'(22));
        assert (accept_cycle == n + 4)
            else report_mismatch("op_ack_o cycle", vreg_t'(accept_cycle), vreg_t'(n + 4));
        op_rdy <= 1'b0;
        drain();

        // a stray write on the idle bus reaches the checker
        repeat (8) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

//--- testbench/vreg_file_model.sv
/*
 * Behavioural vector register file with two combinational reads,
 * a byte-masked write port and a full-register load port.
 */

`timescale 1ns/1ps

module vreg_file_model (
    input  logic             clk_i,
    input  logic             load_en_i,
    input  vmul_pkg::vaddr_t load_addr_i,
    input  vmul_pkg::vreg_t  load_data_i,
    input  vmul_pkg::vaddr_t rd1_addr_i,
    input  vmul_pkg::vaddr_t rd2_addr_i,
    output vmul_pkg::vreg_t  rd1_o,
    output vmul_pkg::vreg_t  rd2_o,
    input  logic             wr_en_i,
    input  vmul_pkg::vaddr_t wr_addr_i,
    input  vmul_pkg::vmsk_t  wr_mask_i,
    input  vmul_pkg::vreg_t  wr_data_i
);

    import vmul_pkg::*;

    vreg_t mem [32];

    assign rd1_o = mem[rd1_addr_i];
    assign rd2_o = mem[rd2_addr_i];

    // masked bytes keep their old contents
    always @(posedge clk_i) begin
        if (load_en_i) begin
            mem[load_addr_i] <= load_data_i;
        end else if (wr_en_i) begin
            for (int b = 0; b < VMSK_W; b++) begin
                if (wr_mask_i[b]) begin
                    mem[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

endmodule
